// File: files.f
hw/clock_pkg.sv
hw/time_if.sv
hw/tick_gen.sv
hw/button_sync.sv
hw/hms_counter.sv
hw/time_keeper.sv
hw/display_scan.sv
hw/digital_clock_top.sv
verification/digital_clock_properties.sv
verification/tb_digital_clock.sv

// File: hw/button_sync.sv
/*
 * Push button front end
 * Two-flop synchronizer, debounce on the slow sample tick
 * and a single press pulse per push
 */
`timescale 1ns/1ns

module button_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_btn,
	output logic o_press
);

	logic [1:0] sync_q;	// Synchronizer chain
	logic       sample_q;	// Previous debounce sample
	logic       level_q;	// Debounced button level
	logic [1:0] samples;

	// Previous and current sample side by side
	assign samples = {sample_q, sync_q[1]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q   <= '0;
			sample_q <= 1'b0;
			level_q  <= 1'b0;
			o_press  <= 1'b0;
		end else begin
			sync_q  <= {sync_q[0], i_btn};
			o_press <= 1'b0;
			if (i_sample) begin
				sample_q <= sync_q[1];
				// Two high samples after a stable low count as one push
				if (samples == 2'b11 && !level_q) begin
					level_q <= 1'b1;
					o_press <= 1'b1;
				end else if (samples == 2'b00) begin
					level_q <= 1'b0;	// Released, armed again
				end
			end
		end
	end

endmodule

// File: hw/clock_pkg.sv
/*
 * Digital clock shared definitions
 * Field widths and limits, setup field codes, display sizes
 * and the decimal-point patterns for run and setup mode
 */
package clock_pkg;

	// ----------------------------------------------------------------------
	// Widths
	// ----------------------------------------------------------------------
	localparam int HMS_W      = 6;	// One time field, 0..59
	localparam int BCD_W      = 4;	// One decimal digit
	localparam int SEG_W      = 7;	// Segments a..g, a in bit 6, active high
	localparam int NUM_DIGITS = 6;
	localparam int FIELD_W    = 2;

	// ----------------------------------------------------------------------
	// Field limits
	// ----------------------------------------------------------------------
	localparam int SEC_MAX  = 59;
	localparam int MIN_MAX  = 59;
	localparam int HOUR_MAX = 23;

	// Setup position codes
	localparam logic [FIELD_W-1:0] FIELD_SEC  = 2'd0;
	localparam logic [FIELD_W-1:0] FIELD_MIN  = 2'd1;
	localparam logic [FIELD_W-1:0] FIELD_HOUR = 2'd2;

	// ----------------------------------------------------------------------
	// Decimal points, bit n belongs to digit n
	// ----------------------------------------------------------------------
	// Run mode marks the ones digits of minutes and hours
	localparam logic [NUM_DIGITS-1:0] DP_RUN  = 6'b010100;

	// Setup mode lights both digits of the selected field
	localparam logic [NUM_DIGITS-1:0] DP_SEC  = 6'b000011;
	localparam logic [NUM_DIGITS-1:0] DP_MIN  = 6'b001100;
	localparam logic [NUM_DIGITS-1:0] DP_HOUR = 6'b110000;

endpackage

// File: hw/digital_clock_top.sv
/*
 * Digital clock top level
 * Tick dividers, button front ends, timekeeping and the
 * multiplexed six-digit display
 */
`timescale 1ns/1ns

module digital_clock_top #(
	parameter int CLK_PER_SEC    = 50_000_000,
	parameter int CLK_PER_SCAN   = 5_000,
	parameter int CLK_PER_SAMPLE = 500_000
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_btn_mode,
	input  logic                           i_btn_pos,
	input  logic                           i_btn_inc,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic                           o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	logic sec_tick;
	logic scan_tick;
	logic sample_tick;
	logic press_mode;
	logic press_pos;
	logic press_inc;

	time_if u_time_if ();

	// ----------------------------------------------------------------------
	// Tick enables
	// ----------------------------------------------------------------------
	tick_gen #(.DIVIDE(CLK_PER_SEC)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIVIDE(CLK_PER_SCAN)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIVIDE(CLK_PER_SAMPLE)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	// Buttons
	button_sync u_btn_mode (.clk(clk), .rst_n(rst_n), .i_sample(sample_tick),
		.i_btn(i_btn_mode), .o_press(press_mode));
	button_sync u_btn_pos (.clk(clk), .rst_n(rst_n), .i_sample(sample_tick),
		.i_btn(i_btn_pos), .o_press(press_pos));
	button_sync u_btn_inc (.clk(clk), .rst_n(rst_n), .i_sample(sample_tick),
		.i_btn(i_btn_inc), .o_press(press_inc));

	time_keeper u_time_keeper (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_sec_tick   (sec_tick),
		.i_press_mode (press_mode),
		.i_press_pos  (press_pos),
		.i_press_inc  (press_inc),
		.tb           (u_time_if.keeper)
	);

	display_scan u_display_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.ti          (u_time_if.display),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

// File: hw/display_scan.sv
/*
 * Six-digit display scanner
 * Splits each field into BCD digits, decodes segments and
 * drives one digit at a time with its decimal point
 */
`timescale 1ns/1ns

module display_scan (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_scan_tick,
	time_if.display                        ti,
	output logic [clock_pkg::SEG_W-1:0]      o_seg,
	output logic                           o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	import clock_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_DIGITS - 1);

	logic [BCD_W-1:0]      digit [NUM_DIGITS];
	logic [NUM_DIGITS-1:0] dp_pat;
	logic [IDX_W-1:0]      idx;
	logic [IDX_W-1:0]      idx_next;

	// Segment table, a in the top bit
	function automatic logic [SEG_W-1:0] seg_decode(input logic [BCD_W-1:0] bcd);
		case (bcd)
			4'd0:    seg_decode = 7'h7E;
			4'd1:    seg_decode = 7'h30;
			4'd2:    seg_decode = 7'h6D;
			4'd3:    seg_decode = 7'h79;
			4'd4:    seg_decode = 7'h33;
			4'd5:    seg_decode = 7'h5B;
			4'd6:    seg_decode = 7'h5F;
			4'd7:    seg_decode = 7'h70;
			4'd8:    seg_decode = 7'h7F;
			4'd9:    seg_decode = 7'h73;
			default: seg_decode = 7'h00;	// Blank
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// BCD split, digit 0 is seconds ones
	// ----------------------------------------------------------------------
	assign digit[0] = BCD_W'(ti.sec % 6'd10);
	assign digit[1] = BCD_W'(ti.sec / 6'd10);
	assign digit[2] = BCD_W'(ti.min % 6'd10);
	assign digit[3] = BCD_W'(ti.min / 6'd10);
	assign digit[4] = BCD_W'(ti.hour % 6'd10);
	assign digit[5] = BCD_W'(ti.hour / 6'd10);

	// Points follow the selected field while setting
	always_comb begin
		if (!ti.setup) begin
			dp_pat = DP_RUN;
		end else begin
			case (ti.field)
				FIELD_SEC: dp_pat = DP_SEC;
				FIELD_MIN: dp_pat = DP_MIN;
				default:   dp_pat = DP_HOUR;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Scan
	// ----------------------------------------------------------------------
	always_comb begin
		if (!i_scan_tick) begin
			idx_next = idx;
		end else if (idx == IDX_LAST) begin
			idx_next = '0;
		end else begin
			idx_next = idx + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= IDX_LAST;	// First tick lands on digit 0
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= '1;	// All digits off
		end else begin
			idx      <= idx_next;
			o_seg    <= seg_decode(digit[idx_next]);
			o_seg_dp <= dp_pat[idx_next];
			if (i_scan_tick) begin
				o_seg_enb <= ~(NUM_DIGITS'(1) << idx_next);
			end
		end
	end

endmodule

// File: hw/hms_counter.sv
/*
 * Time field counter
 * Counts 0..MAX_COUNT on each increment, flags the wrap to zero
 */
`timescale 1ns/1ns

module hms_counter #(
	parameter int MAX_COUNT = 59
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      i_inc,
	output logic [clock_pkg::HMS_W-1:0] o_value,
	output logic                      o_wrap
);

	import clock_pkg::*;

	logic at_max;

	assign at_max = (o_value == HMS_W'(MAX_COUNT));

	// Same cycle as the increment, so the next field steps on the same edge
	assign o_wrap = i_inc & at_max;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_value <= '0;
		end else if (i_inc) begin
			if (at_max) begin
				o_value <= '0;
			end else begin
				o_value <= o_value + 1'b1;
			end
		end
	end

endmodule

// File: hw/tick_gen.sv
/*
 * Tick generator
 * One-cycle enable every DIVIDE clocks
 */
`timescale 1ns/1ns

module tick_gen #(
	parameter int DIVIDE = 1000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CNT_W'(DIVIDE - 1)) begin
			cnt    <= '0;	// Restart and fire
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// File: hw/time_if.sv
/*
 * Time interface
 * Current hours, minutes, seconds and setup state,
 * driven by the timekeeper and read by the display
 */
`timescale 1ns/1ns

interface time_if;
	import clock_pkg::*;

	logic [HMS_W-1:0]   sec;
	logic [HMS_W-1:0]   min;
	logic [HMS_W-1:0]   hour;
	logic               setup;	// High while the time is being set
	logic [FIELD_W-1:0] field;	// Field selected for increment

	modport keeper (
		output sec, min, hour, setup, field
	);

	modport display (
		input  sec, min, hour, setup, field
	);

endinterface

// File: hw/time_keeper.sv
/*
 * Timekeeper
 * Run and setup mode, setup field selection and the three
 * chained counters for seconds, minutes and hours
 */
`timescale 1ns/1ns

module time_keeper (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sec_tick,
	input  logic i_press_mode,
	input  logic i_press_pos,
	input  logic i_press_inc,
	time_if.keeper tb
);

	import clock_pkg::*;

	logic               setup;
	logic [FIELD_W-1:0] field;

	logic sec_inc;
	logic min_inc;
	logic hour_inc;
	logic sec_wrap;
	logic min_wrap;

	// ----------------------------------------------------------------------
	// Mode and setup position
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			setup <= 1'b0;	// Run mode
			field <= FIELD_SEC;
		end else begin
			if (i_press_mode) begin
				setup <= ~setup;
			end
			if (i_press_pos) begin
				// sec -> min -> hour -> sec
				if (field == FIELD_HOUR) begin
					field <= FIELD_SEC;
				end else begin
					field <= field + 1'b1;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Increment steering
	// ----------------------------------------------------------------------
	// Run mode chains the carries, setup steps one field with no carry
	always_comb begin
		if (setup) begin
			sec_inc  = i_press_inc && (field == FIELD_SEC);
			min_inc  = i_press_inc && (field == FIELD_MIN);
			hour_inc = i_press_inc && (field == FIELD_HOUR);
		end else begin
			sec_inc  = i_sec_tick;
			min_inc  = sec_wrap;
			hour_inc = min_wrap;
		end
	end

	hms_counter #(
		.MAX_COUNT(SEC_MAX)
	) u_sec (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_inc   (sec_inc),
		.o_value (tb.sec),
		.o_wrap  (sec_wrap)
	);

	hms_counter #(
		.MAX_COUNT(MIN_MAX)
	) u_min (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_inc   (min_inc),
		.o_value (tb.min),
		.o_wrap  (min_wrap)
	);

	// Day rollover has nowhere to go
	hms_counter #(
		.MAX_COUNT(HOUR_MAX)
	) u_hour (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_inc   (hour_inc),
		.o_value (tb.hour),
		.o_wrap  ()
	);

	assign tb.setup = setup;
	assign tb.field = field;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the digital clock testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_digital_clock -f files.f \
	--Mdir obj_dir -o tb_digital_clock
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_digital_clock 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^Simulation finished: PASS$'; then
	exit 0
fi
echo "Pass message not found"
exit 1

// File: verification/clock_stim.txt
# cmd count  hh mm ss  dp (hex, bit n is digit n)
# W n: n seconds then mid-second, M: mode press, P n / I n: position / increment presses
W 0   00 00 00  14
W 5   00 00 05  14
M 0   00 00 05  03
W 3   00 00 05  03
M 0   00 00 05  14
W 60  00 01 05  14
M 0   00 01 05  03
P 1   00 01 05  0C
I 59  00 00 05  0C
I 59  00 59 05  0C
P 1   00 59 05  30
I 5   05 59 05  30
I 23  04 59 05  30
I 19  23 59 05  30
P 1   23 59 05  03
I 54  23 59 59  03
W 2   23 59 59  03
M 0   23 59 59  14
W 1   00 00 00  14
W 2   00 00 02  14

// File: verification/digital_clock_properties.sv
/*
 * Timekeeper assertions
 * Field ranges, setup position code and frozen time in setup mode
 */
`timescale 1ns/1ns

module digital_clock_properties (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          i_press_inc,
	input logic                          setup,
	input logic [clock_pkg::FIELD_W-1:0] field,
	input logic [clock_pkg::HMS_W-1:0]   sec,
	input logic [clock_pkg::HMS_W-1:0]   min,
	input logic [clock_pkg::HMS_W-1:0]   hour
);

	import clock_pkg::*;

	// ----------------------------------------------------------------------
	// Ranges
	// ----------------------------------------------------------------------
	a_sec_range: assert property (@(posedge clk) disable iff (!rst_n)
		sec <= HMS_W'(SEC_MAX)) else $error("Seconds out of range 0x%h", sec);

	a_min_range: assert property (@(posedge clk) disable iff (!rst_n)
		min <= HMS_W'(MIN_MAX)) else $error("Minutes out of range 0x%h", min);

	a_hour_range: assert property (@(posedge clk) disable iff (!rst_n)
		hour <= HMS_W'(HOUR_MAX)) else $error("Hours out of range 0x%h", hour);

	a_field_code: assert property (@(posedge clk) disable iff (!rst_n)
		field != 2'd3) else $error("Setup field code 3 is unused");

	// Time only moves in setup through an increment press
	a_setup_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		setup && !i_press_inc |=> $stable(sec) && $stable(min) && $stable(hour))
		else $error("Time changed in setup mode without an increment press");

endmodule

bind time_keeper digital_clock_properties u_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_press_inc (i_press_inc),
	.setup       (setup),
	.field       (field),
	.sec         (tb.sec),
	.min         (tb.min),
	.hour        (tb.hour)
);

// File: verification/tb_digital_clock.sv
/*
 * Digital clock testbench
 * Replays button commands and waits from the stimulus file,
 * reads the scanned display back and checks the time it shows
 */
`timescale 1ns/1ns

module tb_digital_clock;

	import clock_pkg::*;

	localparam int SEC_CYC    = 400;
	localparam int SCAN_CYC   = 4;
	localparam int SAMPLE_CYC = 8;
	localparam int PRESS_CYC  = 12 * SAMPLE_CYC;	// 6 samples high, 6 low
	localparam int MODE_PHASE = 240;	// Mode presses start here, clear of ticks
	localparam int CAP_CYC    = SCAN_CYC * NUM_DIGITS;

	// Segment patterns 0..9, a in bit 6
	localparam logic [SEG_W-1:0] SEG_TAB [10] = '{
		7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70, 7'h7F, 7'h73
	};

	typedef struct packed {
		byte cmd;
		int  arg;
		int  hh;
		int  mm;
		int  ss;
		int  dp;
	} step_t;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  btn_mode;
	logic                  btn_pos;
	logic                  btn_inc;
	logic [SEG_W-1:0]      seg;
	logic                  seg_dp;
	logic [NUM_DIGITS-1:0] seg_enb;

	int cyc = 0;	// Clocks since reset release
	int budget_cyc = 0;
	int field_errs = 0;
	int seg_errs = 0;
	int dp_errs = 0;
	int scan_errs = 0;
	int file_errs = 0;

	step_t                 step_q [$];
	logic [SEG_W-1:0]      cap_seg [NUM_DIGITS];
	logic [NUM_DIGITS-1:0] cap_dp;

	digital_clock_top #(
		.CLK_PER_SEC    (SEC_CYC),
		.CLK_PER_SCAN   (SCAN_CYC),
		.CLK_PER_SAMPLE (SAMPLE_CYC)
	) u_digital_clock_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_btn_mode (btn_mode),
		.i_btn_pos  (btn_pos),
		.i_btn_inc  (btn_inc),
		.o_seg      (seg),
		.o_seg_dp   (seg_dp),
		.o_seg_enb  (seg_enb)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
		end
	end

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------
	task automatic check_field(input string name, input logic [HMS_W-1:0] got,
			input logic [HMS_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			field_errs++;
		end
	endtask

	task automatic check_seg(input string name, input logic [SEG_W-1:0] got,
			input logic [SEG_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			seg_errs++;
		end
	endtask

	task automatic check_dp(input string name, input logic [NUM_DIGITS-1:0] got,
			input logic [NUM_DIGITS-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			dp_errs++;
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus file
	// ----------------------------------------------------------------------
	function automatic int step_cycles(input step_t st);
		case (st.cmd)
			"W":     return (st.arg + 1) * SEC_CYC + CAP_CYC;
			"M":     return SEC_CYC + PRESS_CYC + CAP_CYC;
			default: return st.arg * PRESS_CYC + CAP_CYC;
		endcase
	endfunction

	task automatic load_stimulus(output bit ok);
		int    fd;
		int    n;
		int    total;
		string line;
		step_t st;
		ok    = 1'b0;
		total = 0;
		fd    = $fopen("verification/clock_stim.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %d %d %d %d %h", st.cmd, st.arg, st.hh, st.mm,
						st.ss, st.dp);
					if (n != 6) begin
						$display("Stimulus line could not be parsed: %s", line);
						file_errs++;
					end else begin
						step_q.push_back(st);
						total += step_cycles(st);
					end
				end
			end
			$fclose(fd);
			budget_cyc = 2 * total + 8;	// Watchdog starts on this
		end
	endtask

	// ----------------------------------------------------------------------
	// Drivers, all on the falling edge
	// ----------------------------------------------------------------------
	task automatic press_button(input int which);
		case (which)
			0:       btn_mode = 1'b1;
			1:       btn_pos  = 1'b1;
			default: btn_inc  = 1'b1;
		endcase
		repeat (PRESS_CYC / 2) @(negedge clk);
		btn_mode = 1'b0;
		btn_pos  = 1'b0;
		btn_inc  = 1'b0;
		repeat (PRESS_CYC / 2) @(negedge clk);	// Let the debouncer see it released
	endtask

	// n second ticks, ending in the middle of a second
	task automatic wait_seconds(input int n);
		int target;
		target = (cyc / SEC_CYC + n) * SEC_CYC + SEC_CYC / 2;
		while (cyc < target) begin
			@(negedge clk);
		end
	endtask

	task automatic align_mode_press();
		while (cyc % SEC_CYC != MODE_PHASE) begin
			@(negedge clk);
		end
	endtask

	task automatic run_step(input step_t st);
		case (st.cmd)
			"W": wait_seconds(st.arg);
			"M": begin
				align_mode_press();
				press_button(0);
			end
			"P": repeat (st.arg) press_button(1);
			"I": repeat (st.arg) press_button(2);
			default: begin
				$display("Unknown stimulus command %c", st.cmd);
				file_errs++;
			end
		endcase
	endtask

	// ----------------------------------------------------------------------
	// Display readback
	// ----------------------------------------------------------------------
	// One full scan, each digit is enabled for SCAN_CYC clocks
	task automatic capture_display();
		logic [NUM_DIGITS-1:0] seen;
		int                    lows;
		int                    idx;
		seen = '0;
		repeat (CAP_CYC) begin
			@(negedge clk);
			lows = 0;
			idx  = 0;
			for (int d = 0; d < NUM_DIGITS; d++) begin
				if (!seg_enb[d]) begin
					lows++;
					idx = d;
				end
			end
			if (lows != 1) begin
				$display("Display scan broken at %0t ns, %0d digits enabled", $time, lows);
				scan_errs++;
			end else begin
				seen[idx]    = 1'b1;
				cap_seg[idx] = seg;
				cap_dp[idx]  = seg_dp;
			end
		end
		if (seen != '1) begin
			$display("Display scan missed digits, seen mask %b", seen);
			scan_errs++;
		end
	endtask

	function automatic int seg_to_digit(input logic [SEG_W-1:0] s);
		int d;
		d = 0;
		for (int i = 0; i < 10; i++) begin
			if (SEG_TAB[i] == s) begin
				d = i;
			end
		end
		return d;
	endfunction

	task automatic verify_display(input step_t st);
		int exp_dig [NUM_DIGITS];
		int got_dig [NUM_DIGITS];
		exp_dig[0] = st.ss % 10;
		exp_dig[1] = st.ss / 10;
		exp_dig[2] = st.mm % 10;
		exp_dig[3] = st.mm / 10;
		exp_dig[4] = st.hh % 10;
		exp_dig[5] = st.hh / 10;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			check_seg($sformatf("o_seg digit %0d", d), cap_seg[d], SEG_TAB[exp_dig[d]]);
			got_dig[d] = seg_to_digit(cap_seg[d]);
		end
		check_field("hours", HMS_W'(got_dig[5] * 10 + got_dig[4]), HMS_W'(st.hh));
		check_field("minutes", HMS_W'(got_dig[3] * 10 + got_dig[2]), HMS_W'(st.mm));
		check_field("seconds", HMS_W'(got_dig[1] * 10 + got_dig[0]), HMS_W'(st.ss));
		check_dp("o_seg_dp", cap_dp, NUM_DIGITS'(st.dp));
	endtask

	// ----------------------------------------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------------------------------------
	initial begin
		bit ok;
		rst_n    = 1'b0;
		btn_mode = 1'b0;
		btn_pos  = 1'b0;
		btn_inc  = 1'b0;
		load_stimulus(ok);
		if (!ok) begin
			$display("Stimulus file verification/clock_stim.txt could not be opened");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			repeat (4) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			foreach (step_q[i]) begin
				run_step(step_q[i]);
				capture_display();
				verify_display(step_q[i]);
			end
			$display("Errors: field %0d, seg %0d, dp %0d, scan %0d, file %0d",
				field_errs, seg_errs, dp_errs, scan_errs, file_errs);
			if (field_errs + seg_errs + dp_errs + scan_errs + file_errs == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

	initial begin
		wait (budget_cyc > 0);
		repeat (budget_cyc) @(posedge clk);
		$display("Watchdog expired after %0d clocks, the test did not finish", budget_cyc);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
